/* logic/dcp_pkg.sv */
package dcp_pkg;

    // decoded command
    typedef enum logic [1:0] {
        op_print,
        op_reg,
        op_dump,
        op_bad
    } opcode_e;

    typedef enum logic [1:0] {
        scan_cmd,   // waiting for the command letter
        scan_arg,   // collecting hex digits
        scan_hold   // command parked until the core takes it
    } scan_state_e;

    typedef enum logic [1:0] {
        core_idle,
        core_fetch,
        core_send,
        core_next
    } core_state_e;

    // ascii codes
    localparam logic [7:0] char_p     = 8'h50;
    localparam logic [7:0] char_r     = 8'h52;
    localparam logic [7:0] char_d     = 8'h44;
    localparam logic [7:0] char_cr    = 8'h0D;
    localparam logic [7:0] char_lf    = 8'h0A;
    localparam logic [7:0] char_space = 8'h20;
    localparam logic [7:0] char_quest = 8'h3F;

    localparam int dump_words = 8;  // words per D command
    localparam int word_step  = 4;  // byte address step
    localparam int hex_digits = 8;  // chars per word and argument digit limit

endpackage

/* logic/cmd_scanner.sv */
`timescale 1ns/1ps

module cmd_scanner (
    input  logic             clk,
    input  logic             rst,
    input  logic [7:0]       d_rx,
    input  logic             vld_rx,
    output logic             rdy_rx,
    output logic             cmd_valid,
    output dcp_pkg::opcode_e cmd_op,
    output logic [31:0]      cmd_arg,
    input  logic             cmd_ready
);

    dcp_pkg::scan_state_e state;
    logic [3:0] n_digits;   // digits shifted in so far
    logic       rx_fire;
    logic       is_end;
    logic       is_space;
    logic [4:0] hex_dec;
    logic       is_hex;
    logic [3:0] nibble;

    // bit 4 set when c is a hex digit of either case
    function automatic logic [4:0] hex_decode(input logic [7:0] c);
        logic [7:0] v;
        logic       ok;
        ok = 1'b1;
        v  = 8'h00;
        if (c >= "0" && c <= "9") begin
            v = c - 8'h30;
        end else if (c >= "A" && c <= "F") begin
            v = c - 8'h37;
        end else if (c >= "a" && c <= "f") begin
            v = c - 8'h57;
        end else begin
            ok = 1'b0;
        end
        return {ok, v[3:0]};
    endfunction

    assign rdy_rx    = (state != dcp_pkg::scan_hold);
    assign cmd_valid = (state == dcp_pkg::scan_hold);
    assign rx_fire   = vld_rx && rdy_rx;
    assign is_end    = (d_rx == dcp_pkg::char_cr) || (d_rx == dcp_pkg::char_lf);
    assign is_space  = (d_rx == dcp_pkg::char_space);
    assign hex_dec   = hex_decode(d_rx);
    assign is_hex    = hex_dec[4];
    assign nibble    = hex_dec[3:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= dcp_pkg::scan_cmd;
            n_digits <= '0;
        end else begin
            case (state)
                dcp_pkg::scan_cmd: begin
                    // blanks and stray line ends before a letter are dropped
                    if (rx_fire && !is_end && !is_space) begin
                        n_digits <= '0;
                        state    <= dcp_pkg::scan_arg;
                    end
                end
                dcp_pkg::scan_arg: begin
                    if (rx_fire) begin
                        if (is_end) begin
                            state <= dcp_pkg::scan_hold;
                        end else if (is_hex && n_digits < dcp_pkg::hex_digits) begin
                            n_digits <= n_digits + 4'd1;
                        end
                    end
                end
                default: begin
                    if (cmd_ready) begin
                        state <= dcp_pkg::scan_cmd;
                    end
                end
            endcase
        end
    end

    // opcode and argument registers
    always_ff @(posedge clk) begin
        if (state == dcp_pkg::scan_cmd && rx_fire && !is_end && !is_space) begin
            cmd_arg <= '0;  // no digits means address zero
            case (d_rx)
                dcp_pkg::char_p: cmd_op <= dcp_pkg::op_print;
                dcp_pkg::char_r: cmd_op <= dcp_pkg::op_reg;
                dcp_pkg::char_d: cmd_op <= dcp_pkg::op_dump;
                default:         cmd_op <= dcp_pkg::op_bad;
            endcase
        end else if (state == dcp_pkg::scan_arg && rx_fire && !is_end && !is_space) begin
            if (is_hex && n_digits < dcp_pkg::hex_digits) begin
                cmd_arg <= {cmd_arg[27:0], nibble};
            end else begin
                cmd_op <= dcp_pkg::op_bad;   // junk char or too many digits
            end
        end
    end

    // a parked command must not change under the core
    a_cmd_stable: assert property (@(posedge clk) disable iff (rst)
        cmd_valid && !cmd_ready |=> $stable(cmd_op) && $stable(cmd_arg));

endmodule

/* logic/dcp_core.sv */
`timescale 1ns/1ps

module dcp_core (
    input  logic             clk,
    input  logic             rst,
    input  logic             cmd_valid,
    input  dcp_pkg::opcode_e cmd_op,
    input  logic [31:0]      cmd_arg,
    output logic             cmd_ready,
    input  logic [31:0]      pc,
    input  logic [31:0]      ir,
    output logic [31:0]      addr,
    input  logic [31:0]      dout_rf,
    input  logic [31:0]      dout_dm,
    output logic             word_valid,
    input  logic             word_ready,
    output logic [31:0]      word_data,
    output logic             word_bad
);

    dcp_pkg::core_state_e state;
    dcp_pkg::opcode_e     op;         // command being run
    logic [$clog2(dcp_pkg::dump_words)-1:0] word_cnt;
    logic                 last_word;
    logic [31:0]          src_data;

    assign cmd_ready  = (state == dcp_pkg::core_idle);
    assign word_valid = (state == dcp_pkg::core_send);

    // the opcode picks the source, so one addr serves rf and dm
    always_comb begin
        case (op)
            dcp_pkg::op_print: src_data = (word_cnt == '0) ? pc : ir;
            dcp_pkg::op_reg:   src_data = dout_rf;
            dcp_pkg::op_dump:  src_data = dout_dm;
            default:           src_data = '0;
        endcase
    end

    always_comb begin
        case (op)
            dcp_pkg::op_print: last_word = (word_cnt == 1);  // pc then ir
            dcp_pkg::op_dump:  last_word = (word_cnt == dcp_pkg::dump_words - 1);
            default:           last_word = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= dcp_pkg::core_idle;
            op       <= dcp_pkg::op_print;
            word_cnt <= '0;
            addr     <= '0;
        end else begin
            case (state)
                dcp_pkg::core_idle: begin
                    if (cmd_valid) begin
                        op       <= cmd_op;
                        addr     <= cmd_arg;
                        word_cnt <= '0;
                        state    <= dcp_pkg::core_fetch;
                    end
                end
                dcp_pkg::core_fetch: begin
                    state <= dcp_pkg::core_send;   // read data latched here
                end
                dcp_pkg::core_send: begin
                    if (word_ready) begin
                        state <= last_word ? dcp_pkg::core_idle : dcp_pkg::core_next;
                    end
                end
                default: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (op == dcp_pkg::op_dump) begin
                        addr <= addr + 32'(dcp_pkg::word_step);
                    end
                    state <= dcp_pkg::core_fetch;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcp_pkg::core_fetch) begin
            word_data <= src_data;
            word_bad  <= (op == dcp_pkg::op_bad);
        end
    end

    // offered word held until the emitter takes it
    a_word_hold: assert property (@(posedge clk) disable iff (rst)
        word_valid && !word_ready |=> word_valid && $stable(word_data));

endmodule

/* logic/hex_emitter.sv */
`timescale 1ns/1ps

module hex_emitter (
    input  logic        clk,
    input  logic        rst,
    input  logic        word_valid,
    input  logic [31:0] word_data,
    input  logic        word_bad,
    output logic        word_ready,
    output logic [7:0]  d_tx,
    output logic        vld_tx,
    input  logic        rdy_tx
);

    logic        busy;
    logic        bad;
    logic [31:0] shreg;      // top nibble is the next digit
    logic [3:0]  char_cnt;
    logic [3:0]  tail_pos;   // index of the CR
    logic        tx_fire;
    logic        last_char;

    assign word_ready = !busy;
    assign vld_tx     = busy;
    assign tx_fire    = vld_tx && rdy_tx;
    assign tail_pos   = bad ? 4'd1 : 4'(dcp_pkg::hex_digits);
    assign last_char  = (char_cnt == tail_pos + 4'd1);   // the LF

    always_comb begin
        if (bad && char_cnt == '0) begin
            d_tx = dcp_pkg::char_quest;
        end else if (char_cnt < tail_pos) begin
            // 0x37 + 10 gives uppercase 'A'
            d_tx = (shreg[31:28] < 4'd10) ? {4'h3, shreg[31:28]} : 8'h37 + shreg[31:28];
        end else if (char_cnt == tail_pos) begin
            d_tx = dcp_pkg::char_cr;
        end else begin
            d_tx = dcp_pkg::char_lf;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            char_cnt <= '0;
        end else if (!busy) begin
            if (word_valid) begin
                busy     <= 1'b1;
                char_cnt <= '0;
            end
        end else if (tx_fire) begin
            if (last_char) begin
                busy <= 1'b0;
            end
            char_cnt <= char_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid && word_ready) begin
            shreg <= word_data;
            bad   <= word_bad;
        end else if (tx_fire) begin
            shreg <= shreg << 4;   // next nibble up
        end
    end

    // byte held under back-pressure
    a_tx_hold: assert property (@(posedge clk) disable iff (rst)
        vld_tx && !rdy_tx |=> vld_tx && $stable(d_tx));

endmodule

/* logic/dcp.sv */
`timescale 1ns/1ps

module dcp (
    input  logic        clk,
    input  logic        rst,
    // receive byte stream
    input  logic [7:0]  d_rx,
    input  logic        vld_rx,
    output logic        rdy_rx,
    // transmit byte stream
    output logic [7:0]  d_tx,
    output logic        vld_tx,
    input  logic        rdy_tx,
    // cpu status
    input  logic [31:0] pc,
    input  logic [31:0] ir,
    output logic [31:0] addr,     // shared by rf and dm
    input  logic [31:0] dout_rf,
    input  logic [31:0] dout_dm
);

    logic             cmd_valid;
    logic             cmd_ready;
    dcp_pkg::opcode_e cmd_op;
    logic [31:0]      cmd_arg;
    logic             word_valid;
    logic             word_ready;
    logic [31:0]      word_data;
    logic             word_bad;

    cmd_scanner u_scanner (
        .clk       (clk),
        .rst       (rst),
        .d_rx      (d_rx),
        .vld_rx    (vld_rx),
        .rdy_rx    (rdy_rx),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_arg   (cmd_arg),
        .cmd_ready (cmd_ready)
    );

    dcp_core u_core (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_arg    (cmd_arg),
        .cmd_ready  (cmd_ready),
        .pc         (pc),
        .ir         (ir),
        .addr       (addr),
        .dout_rf    (dout_rf),
        .dout_dm    (dout_dm),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .word_data  (word_data),
        .word_bad   (word_bad)
    );

    hex_emitter u_emitter (
        .clk        (clk),
        .rst        (rst),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_bad   (word_bad),
        .word_ready (word_ready),
        .d_tx       (d_tx),
        .vld_tx     (vld_tx),
        .rdy_tx     (rdy_tx)
    );

endmodule

/* include/dcp_tb_ref.svh */
`ifndef dcp_tb_ref_svh
`define dcp_tb_ref_svh

typedef logic [7:0] byte_q_t [$];

// -1 for anything that is not a hex digit
function automatic int hex_val(input logic [7:0] c);
    if (c >= "0" && c <= "9") return int'(c) - 48;
    if (c >= "a" && c <= "f") return int'(c) - 87;
    if (c >= "A" && c <= "F") return int'(c) - 55;
    return -1;
endfunction

function automatic logic [7:0] hex_char(input logic [3:0] n);
    if (n < 4'd10) return 8'h30 + 8'(n);
    return 8'h41 + 8'(n) - 8'd10;   // uppercase letters
endfunction

// expected answer bytes for one command body without its line end
function automatic byte_q_t ref_answer(input string body, input logic [31:0] cur_pc,
                                       input logic [31:0] cur_ir);
    byte_q_t     q;
    logic [31:0] words [$];
    logic [31:0] arg;
    logic [31:0] a;
    logic [31:0] cur;
    logic [7:0]  c;
    logic [7:0]  letter;
    int          ndig;
    int          v;
    int          i;
    int          k;
    bit          bad;
    arg    = '0;
    ndig   = 0;
    bad    = 1'b0;
    letter = 8'h00;
    for (i = 0; i < body.len(); i++) begin
        c = body[i];
        v = hex_val(c);
        if (c != " ") begin
            if (letter == 8'h00) begin
                letter = c;
            end else if (v >= 0 && ndig < 8) begin
                arg  = {arg[27:0], 4'(v)};
                ndig = ndig + 1;
            end else begin
                bad = 1'b1;   // junk or a ninth digit
            end
        end
    end
    case (letter)
        "P": begin
            words.push_back(cur_pc);
            words.push_back(cur_ir);
        end
        "R": words.push_back(rf_mem[arg[4:0]]);
        "D": begin
            for (k = 0; k < dump_len; k++) begin
                a = arg + 32'(4 * k);
                words.push_back(dm_mem[a[9:2]]);
            end
        end
        default: bad = 1'b1;
    endcase
    if (bad) begin
        q.push_back(8'h3F);
        q.push_back(cr);
        q.push_back(lf);
    end else begin
        foreach (words[w]) begin
            cur = words[w];
            for (k = 7; k >= 0; k--) begin
                q.push_back(hex_char(cur[4*k +: 4]));
            end
            q.push_back(cr);
            q.push_back(lf);
        end
    end
    return q;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
        stop_fail();
    end
endtask

`endif

/* tests/dcp_tb.sv */
`timescale 1ns/1ps

module dcp_tb;

    localparam logic [7:0] cr = 8'h0D;
    localparam logic [7:0] lf = 8'h0A;
    localparam int dump_len = 8;      // words per D answer
    localparam int rx_limit = 5000;   // cycles waiting on rdy_rx
    localparam int tx_limit = 5000;   // cycles waiting for an answer

    logic        clk;
    logic        rst;
    logic [7:0]  d_rx;
    logic        vld_rx;
    logic        rdy_rx;
    logic [7:0]  d_tx;
    logic        vld_tx;
    logic        rdy_tx;
    logic [31:0] pc;
    logic [31:0] ir;
    logic [31:0] addr;
    logic [31:0] dout_rf;
    logic [31:0] dout_dm;
    logic [31:0] rf_mem [32];
    logic [31:0] dm_mem [256];
    bit          bp_on;
    int          n_checked;

    task automatic stop_fail;
        $display("Verification failed");
        $fatal(1);
    endtask

    `include "dcp_tb_ref.svh"

    byte_q_t exp_q;   // bytes still owed by the DUT

    dcp UUT (
        .clk     (clk),
        .rst     (rst),
        .d_rx    (d_rx),
        .vld_rx  (vld_rx),
        .rdy_rx  (rdy_rx),
        .d_tx    (d_tx),
        .vld_tx  (vld_tx),
        .rdy_tx  (rdy_tx),
        .pc      (pc),
        .ir      (ir),
        .addr    (addr),
        .dout_rf (dout_rf),
        .dout_dm (dout_dm)
    );

    // combinational memory models
    assign dout_rf = rf_mem[addr[4:0]];
    assign dout_dm = dm_mem[addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // random stalls on the transmit side
    initial begin
        rdy_tx = 1'b1;
        forever begin
            @(negedge clk);
            rdy_tx = bp_on ? ($urandom_range(3) != 0) : 1'b1;
        end
    end

    // compare every accepted output byte
    always @(posedge clk) begin
        if (!rst && vld_tx && rdy_tx) begin
            if (exp_q.size() == 0) begin
                $display("d_tx sent a byte while no answer was pending");
                stop_fail();
            end else begin
                check_value("d_tx", {24'h0, exp_q.pop_front()}, {24'h0, d_tx});
                n_checked = n_checked + 1;
            end
        end
    end

    task automatic push_byte(input logic [7:0] b);
        int t;
        t = 0;
        @(negedge clk);
        d_rx   = b;
        vld_rx = 1'b1;
        @(posedge clk);
        while (!rdy_rx) begin
            t = t + 1;
            if (t > rx_limit) begin
                $display("receive stream stalled, rdy_rx stayed low");
                stop_fail();
            end
            @(posedge clk);
        end
    endtask

    task automatic send_cmd(input string body, input logic [7:0] term);
        byte_q_t ans;
        int      i;
        ans = ref_answer(body, pc, ir);
        foreach (ans[k]) exp_q.push_back(ans[k]);
        for (i = 0; i < body.len(); i++) begin
            push_byte(body[i]);
        end
        push_byte(term);
        @(negedge clk);
        vld_rx = 1'b0;
    endtask

    task automatic wait_done;
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            t = t + 1;
            if (t > tx_limit) begin
                $display("answer never completed, %0d bytes missing", exp_q.size());
                stop_fail();
            end
        end
    endtask

    task automatic new_cpu_state;
        @(negedge clk);
        pc = $urandom;
        ir = $urandom;
    endtask

    task automatic run_one(input string body, input logic [7:0] term);
        new_cpu_state();
        send_cmd(body, term);
        wait_done();
    endtask

    initial begin
        int j;
        void'($urandom(5121));
        rst       = 1'b1;
        d_rx      = 8'h00;
        vld_rx    = 1'b0;
        pc        = '0;
        ir        = '0;
        bp_on     = 1'b0;
        n_checked = 0;
        foreach (rf_mem[k]) rf_mem[k] = $urandom;
        foreach (dm_mem[k]) dm_mem[k] = $urandom;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_one("P", cr);
        run_one("R 1f", cr);
        run_one("  R 0A", lf);
        run_one("R", cr);             // no digits means address zero
        run_one("R 0000001B", lf);
        run_one("D 40", cr);
        run_one(" D ffc", cr);        // wraps around the model
        run_one("X", cr);
        run_one("R 1G", cr);
        run_one("D 123456789", lf);   // one digit too many
        run_one("R 5", cr);

        bp_on = 1'b1;
        for (j = 0; j < 6; j++) begin
            run_one($sformatf("D %h", $urandom), cr);
            run_one($sformatf("R %0h", $urandom_range(31)), lf);
            run_one("P", cr);
        end

        // commands queued without waiting for answers
        new_cpu_state();
        send_cmd("P", cr);
        send_cmd("R 2", cr);
        send_cmd("D 100", lf);
        send_cmd("Q", cr);
        send_cmd(" R 1e", cr);
        send_cmd("D 7fC", cr);
        wait_done();

        $display("%0d output bytes checked", n_checked);
        $display("Verification passed");
        $finish;
    end

endmodule

/* dcp.f */
+incdir+include
logic/dcp_pkg.sv
logic/cmd_scanner.sv
logic/dcp_core.sv
logic/hex_emitter.sv
logic/dcp.sv
tests/dcp_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only -Wall --timing
TOP       = dcp_tb
RTL_TOP   = dcp
FILELIST  = dcp.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
